//--- Bender.yml
package:
  name: sifh

sources:
  - rtl/sifhPkg.sv
  - rtl/histRam.sv
  - rtl/eventGate.sv
  - rtl/histBuilder.sv
  - rtl/peakFinder.sv
  - rtl/sifhSequencer.sv
  - rtl/sifhTop.sv
  - target: simulation
    files:
      - tests/sifhChecker.sv
      - tests/sifhTb.sv

//--- rtl/eventGate.sv
module eventGate (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        eventValid,
    input  logic [sifhPkg::stampW-1:0]  stamp,
    input  logic                        buildOn,
    input  logic                        pass2,
    input  sifhPkg::window_t            window,
    output sifhPkg::binEvent_t          binEvent
);
    import sifhPkg::*;

    logic [binW-1:0] stampBin;
    logic            inWindow;
    logic            evValid;
    logic [binW-1:0] evBin;

    assign stampBin = stamp[stampW-1 -: binW];   // coarse time bin
    assign inWindow = (stampBin >= window.thLow) && (stampBin <= window.thHigh);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evValid <= 1'b0;
        end else begin
            evValid <= eventValid && buildOn && (!pass2 || inWindow);
        end
    end

    always_ff @(posedge clk) begin
        evBin <= stampBin;
    end

    assign binEvent = '{valid: evValid, bin: evBin};

    // an inverted window would drop every pass-two event
    assert property (@(posedge clk) disable iff (!res)
        pass2 |-> (window.thLow <= window.thHigh));

endmodule

//--- rtl/histBuilder.sv
module histBuilder (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        clearStart,
    input  sifhPkg::binEvent_t          binEvent,
    input  logic [sifhPkg::countW-1:0]  rdData,
    output sifhPkg::ramRd_t             ramRd,
    output sifhPkg::ramWr_t             ramWr,
    output logic                        clearDone,
    output logic                        pipeEmpty
);
    import sifhPkg::*;

    logic              clearing;
    logic [binW-1:0]   clearAddr;

    logic              s1Valid;     // read data returning
    logic [binW-1:0]   s1Bin;
    logic              s2Valid;     // write in this cycle
    logic [binW-1:0]   s2Bin;
    logic [countW-1:0] s2Count;
    logic              s3Valid;     // written last cycle, not yet visible to a read
    logic [binW-1:0]   s3Bin;
    logic [countW-1:0] s3Count;

    logic [countW-1:0] baseCount;
    logic [countW-1:0] incCount;

    // clear sweep, one zero write per cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing  <= 1'b0;
            clearAddr <= '0;
            clearDone <= 1'b0;
        end else begin
            clearDone <= 1'b0;
            if (clearStart) begin
                clearing  <= 1'b1;
                clearAddr <= '0;
            end else if (clearing) begin
                clearAddr <= clearAddr + 1'b1;
                if (clearAddr == binW'(binNum - 1)) begin
                    clearing  <= 1'b0;
                    clearDone <= 1'b1;   // cycle after the last write
                end
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= binEvent.valid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= binEvent.bin;
        s2Bin   <= s1Bin;
        s2Count <= incCount;
        s3Bin   <= s2Bin;
        s3Count <= s2Count;
    end

    // newest in-flight value wins over the RAM copy
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            baseCount = s2Count;
        end else if (s3Valid && (s3Bin == s1Bin)) begin
            baseCount = s3Count;
        end else begin
            baseCount = rdData;
        end
        incCount = (&baseCount) ? baseCount : baseCount + 1'b1;   // saturate
    end

    assign ramRd = '{en: binEvent.valid, addr: binEvent.bin};

    always_comb begin
        if (clearing) begin
            ramWr = '{en: 1'b1, addr: clearAddr, data: '0};
        end else begin
            ramWr = '{en: s2Valid, addr: s2Bin, data: s2Count};
        end
    end

    assign pipeEmpty = !binEvent.valid && !s1Valid && !s2Valid;

    // the sequencer never opens a build phase before the sweep finishes
    assert property (@(posedge clk) disable iff (!res)
        (clearing || clearStart) |-> !binEvent.valid);

endmodule

//--- rtl/histRam.sv
module histRam (
    input  logic                        clk,
    input  sifhPkg::ramRd_t             ramRd,
    input  sifhPkg::ramWr_t             ramWr,
    output logic [sifhPkg::countW-1:0]  rdData
);
    import sifhPkg::*;

    logic [countW-1:0] mem [binNum];

    always_ff @(posedge clk) begin
        if (ramWr.en) begin
            mem[ramWr.addr] <= ramWr.data;
        end
    end

    // read-before-write on a shared address, histBuilder forwards the new value
    always_ff @(posedge clk) begin
        if (ramRd.en) begin
            rdData <= mem[ramRd.addr];
        end
    end

endmodule

//--- rtl/peakFinder.sv
module peakFinder (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        peakStart,
    input  logic [sifhPkg::countW-1:0]  rdData,
    output sifhPkg::ramRd_t             ramRd,
    output logic                        peakDone,
    output sifhPkg::peak_t              peak
);
    import sifhPkg::*;

    logic              reading;
    logic [binW-1:0]   rdAddr;
    logic              cmpValid;   // rdData belongs to cmpBin
    logic              cmpLast;
    logic [binW-1:0]   cmpBin;
    logic [binW-1:0]   maxBin;
    logic [countW-1:0] maxCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            reading  <= 1'b0;
            rdAddr   <= '0;
            cmpValid <= 1'b0;
            cmpLast  <= 1'b0;
            peakDone <= 1'b0;
        end else begin
            cmpValid <= reading;
            cmpLast  <= reading && (rdAddr == binW'(binNum - 1));
            peakDone <= cmpValid && cmpLast;
            if (peakStart) begin
                reading <= 1'b1;
                rdAddr  <= '0;
            end else if (reading) begin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == binW'(binNum - 1)) begin
                    reading <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= rdAddr;
        if (peakStart) begin
            maxBin   <= '0;
            maxCount <= '0;
        end else if (cmpValid && (rdData > maxCount)) begin
            maxBin   <= cmpBin;     // strictly greater, lowest bin keeps a tie
            maxCount <= rdData;
        end
    end

    assign ramRd = '{en: reading, addr: rdAddr};
    assign peak  = '{bin: maxBin, count: maxCount};

    // a new search never restarts a sweep that is still reading
    assert property (@(posedge clk) disable iff (!res)
        peakStart |-> !reading);

endmodule

//--- rtl/sifhPkg.sv
package sifhPkg;

    localparam int stampW     = 12;          // photon timestamp width
    localparam int binW       = 6;           // top stamp bits form the bin index
    localparam int binNum     = 1 << binW;   // 64 bins per histogram
    localparam int countW     = 16;          // saturating bin counter
    localparam int windowHalf = 4;           // pass-two window, bins each side of the peak

    // run states; the pass number is a separate flag
    typedef enum logic [2:0] {
        sIdle,
        sClear,
        sBuild,
        sDrain,
        sPeak,
        sDone
    } seqState_t;

    typedef struct packed {
        logic            valid;
        logic [binW-1:0] bin;
    } binEvent_t;

    typedef struct packed {
        logic              en;
        logic [binW-1:0]   addr;
        logic [countW-1:0] data;
    } ramWr_t;

    typedef struct packed {
        logic            en;
        logic [binW-1:0] addr;
    } ramRd_t;

    typedef struct packed {
        logic [binW-1:0]   bin;
        logic [countW-1:0] count;
    } peak_t;

    typedef struct packed {
        logic [binW-1:0] thLow;    // TH-
        logic [binW-1:0] thHigh;   // TH+
    } window_t;

endpackage

//--- rtl/sifhSequencer.sv
module sifhSequencer (
    input  logic              clk,
    input  logic              res,
    input  logic              start,
    input  logic              frameEnd,
    input  logic              clearDone,
    input  logic              pipeEmpty,
    input  logic              peakDone,
    input  sifhPkg::peak_t    peak,
    output logic              clearStart,
    output logic              buildOn,
    output logic              peakOn,
    output logic              peakStart,
    output logic              pass2,
    output logic              busy,
    output logic              done,
    output sifhPkg::peak_t    peak1,
    output sifhPkg::peak_t    peak2,
    output sifhPkg::window_t  window
);
    import sifhPkg::*;

    seqState_t state;
    window_t   nextWindow;

    // window around the pass-one peak, clipped to the bin range
    always_comb begin
        if (peak.bin < binW'(windowHalf)) begin
            nextWindow.thLow = '0;
        end else begin
            nextWindow.thLow = peak.bin - binW'(windowHalf);
        end
        if (peak.bin > binW'(binNum - 1 - windowHalf)) begin
            nextWindow.thHigh = binW'(binNum - 1);
        end else begin
            nextWindow.thHigh = peak.bin + binW'(windowHalf);
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= sIdle;
            pass2      <= 1'b0;
            clearStart <= 1'b0;
            peakStart  <= 1'b0;
            peak1      <= '0;
            peak2      <= '0;
            window     <= '0;
        end else begin
            clearStart <= 1'b0;
            peakStart  <= 1'b0;
            case (state)
                sIdle: begin
                    if (start) begin
                        state      <= sClear;
                        pass2      <= 1'b0;
                        clearStart <= 1'b1;
                    end
                end
                sClear: begin
                    if (clearDone) begin
                        state <= sBuild;
                    end
                end
                sBuild: begin
                    if (frameEnd) begin
                        state <= sDrain;
                    end
                end
                sDrain: begin
                    if (pipeEmpty) begin   // last increment has reached the RAM
                        state     <= sPeak;
                        peakStart <= 1'b1;
                    end
                end
                sPeak: begin
                    if (peakDone && pass2) begin
                        peak2 <= peak;
                        state <= sDone;
                    end else if (peakDone) begin
                        peak1      <= peak;
                        window     <= nextWindow;
                        pass2      <= 1'b1;
                        clearStart <= 1'b1;
                        state      <= sClear;
                    end
                end
                sDone: begin
                    pass2 <= 1'b0;
                    state <= sIdle;
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    assign buildOn = (state == sBuild);
    assign peakOn  = (state == sPeak);
    assign busy    = (state != sIdle);
    assign done    = (state == sDone);   // single cycle as sDone always returns to idle

    // the peak search only finishes inside the peak phase
    assert property (@(posedge clk) disable iff (!res)
        peakDone |-> (state == sPeak));

endmodule

//--- rtl/sifhTop.sv
module sifhTop (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        start,
    input  logic                        eventValid,
    input  logic [sifhPkg::stampW-1:0]  stamp,
    input  logic                        frameEnd,
    output logic                        busy,
    output logic                        done,
    output sifhPkg::peak_t              peak1,
    output sifhPkg::peak_t              peak2,
    output sifhPkg::window_t            window
);
    import sifhPkg::*;

    binEvent_t         binEvent;
    ramRd_t            buildRd;
    ramRd_t            peakRd;
    ramRd_t            ramRd;
    ramWr_t            ramWr;
    logic [countW-1:0] rdData;
    peak_t             peakRes;

    logic clearStart;
    logic clearDone;
    logic pipeEmpty;
    logic buildOn;
    logic peakOn;
    logic peakStart;
    logic peakDone;
    logic pass2;

    assign ramRd = peakOn ? peakRd : buildRd;   // read port owner

    eventGate gate0 (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .stamp      (stamp),
        .buildOn    (buildOn),
        .pass2      (pass2),
        .window     (window),
        .binEvent   (binEvent)
    );

    histBuilder builder0 (
        .clk        (clk),
        .res        (res),
        .clearStart (clearStart),
        .binEvent   (binEvent),
        .rdData     (rdData),
        .ramRd      (buildRd),
        .ramWr      (ramWr),
        .clearDone  (clearDone),
        .pipeEmpty  (pipeEmpty)
    );

    histRam ram0 (
        .clk    (clk),
        .ramRd  (ramRd),
        .ramWr  (ramWr),
        .rdData (rdData)
    );

    peakFinder finder0 (
        .clk       (clk),
        .res       (res),
        .peakStart (peakStart),
        .rdData    (rdData),
        .ramRd     (peakRd),
        .peakDone  (peakDone),
        .peak      (peakRes)
    );

    sifhSequencer seq0 (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .frameEnd   (frameEnd),
        .clearDone  (clearDone),
        .pipeEmpty  (pipeEmpty),
        .peakDone   (peakDone),
        .peak       (peakRes),
        .clearStart (clearStart),
        .buildOn    (buildOn),
        .peakOn     (peakOn),
        .peakStart  (peakStart),
        .pass2      (pass2),
        .busy       (busy),
        .done       (done),
        .peak1      (peak1),
        .peak2      (peak2),
        .window     (window)
    );

endmodule

//--- sifhTop.f
rtl/sifhPkg.sv
rtl/histRam.sv
rtl/eventGate.sv
rtl/histBuilder.sv
rtl/peakFinder.sv
rtl/sifhSequencer.sv
rtl/sifhTop.sv
tests/sifhChecker.sv
tests/sifhTb.sv

//--- tests/sifhChecker.sv
module sifhChecker (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        start,
    input  logic                        eventValid,
    input  logic [sifhPkg::stampW-1:0]  stamp,
    input  logic                        frameEnd,
    input  logic                        busy,
    input  logic                        done,
    input  sifhPkg::peak_t              peak1,
    input  sifhPkg::peak_t              peak2,
    input  sifhPkg::window_t            window,
    input  sifhPkg::peak_t              expPeak1,
    input  sifhPkg::peak_t              expPeak2,
    input  sifhPkg::window_t            expWindow,
    output int                          valueErrors,
    output int                          modelErrors,
    output int                          protocolErrors
);
    timeunit 1ns;
    timeprecision 100ps;
    import sifhPkg::*;

    // the trace keeps events well clear of these phase edges
    localparam int openOne  = binNum + 8;        // first clear sweep is over
    localparam int openTwo  = 3 * binNum + 16;   // drain, peak search, second clear
    localparam int countMax = (1 << countW) - 1;

    int      histOne [binNum];
    int      histTwo [binNum];
    int      phase   = 0;   // 0 idle, 1 pass one, 2 pass two, 3 waiting for done
    int      since   = 0;   // cycles since the phase opened
    bit      resSeen = 1'b0;
    int      valErr  = 0;
    int      modErr  = 0;
    int      protErr = 0;
    peak_t   modelPeak1;
    window_t modelWindow;

    assign valueErrors    = valErr;
    assign modelErrors    = modErr;
    assign protocolErrors = protErr;

    function automatic peak_t peakOf(input bit second);
        peak_t best;
        int    cnt;
        best = '0;
        for (int b = 0; b < binNum; b++) begin
            cnt = second ? histTwo[b] : histOne[b];
            if (cnt > int'(best.count)) begin   // lowest bin keeps a tie
                best.bin   = binW'(b);
                best.count = countW'(cnt);
            end
        end
        return best;
    endfunction

    function automatic window_t windowAround(input peak_t p);
        int lo;
        int hi;
        lo = int'(p.bin) - windowHalf;
        hi = int'(p.bin) + windowHalf;
        if (lo < 0) begin
            lo = 0;
        end
        if (hi > binNum - 1) begin
            hi = binNum - 1;
        end
        return '{thLow: binW'(lo), thHigh: binW'(hi)};
    endfunction

    task automatic addEvent(input logic [stampW-1:0] st);
        int b;
        b = int'(st[stampW-1 -: binW]);   // top stamp bits
        if (phase == 1 && since >= openOne && histOne[b] < countMax) begin
            histOne[b]++;
        end else if (phase == 2 && since >= openTwo && histTwo[b] < countMax
                     && b >= int'(modelWindow.thLow) && b <= int'(modelWindow.thHigh)) begin
            histTwo[b]++;
        end
    endtask

    task automatic compareRun(input bit vsModel, input peak_t p1, input window_t w,
                              input peak_t p2);
        string src;
        int    bad;
        src = vsModel ? "model" : "trace";
        bad = 0;
        if (peak1 !== p1) begin
            $display("Error at %0t: pass-one peak bin %0d count %0d, %s gives bin %0d count %0d",
                     $time, peak1.bin, peak1.count, src, p1.bin, p1.count);
            bad++;
        end
        if (window !== w) begin
            $display("Error at %0t: window %0d..%0d, %s gives %0d..%0d",
                     $time, window.thLow, window.thHigh, src, w.thLow, w.thHigh);
            bad++;
        end
        if (peak2 !== p2) begin
            $display("Error at %0t: pass-two peak bin %0d count %0d, %s gives bin %0d count %0d",
                     $time, peak2.bin, peak2.count, src, p2.bin, p2.count);
            bad++;
        end
        if (vsModel) begin
            modErr += bad;
        end else begin
            valErr += bad;
        end
    endtask

    // falling edge, inputs and outputs are both settled
    always @(negedge clk) begin
        if (!res) begin
            phase = 0;
        end else begin
            if (!resSeen) begin
                resSeen = 1'b1;
                if (busy || done || peak1 !== '0 || peak2 !== '0 || window !== '0) begin
                    $display("outputs are not idle and zero after reset");
                    protErr++;
                end
            end
            since = since + 1;
            if (eventValid) begin
                addEvent(stamp);
            end
            if (start && !busy && phase == 0) begin
                for (int b = 0; b < binNum; b++) begin
                    histOne[b] = 0;
                    histTwo[b] = 0;
                end
                phase = 1;
                since = 0;
            end else if (frameEnd && phase == 1) begin
                modelPeak1  = peakOf(1'b0);
                modelWindow = windowAround(modelPeak1);
                phase       = 2;
                since       = 0;
            end else if (frameEnd && phase == 2) begin
                phase = 3;
            end
            if (done && phase == 3) begin
                compareRun(1'b0, expPeak1, expWindow, expPeak2);
                compareRun(1'b1, modelPeak1, modelWindow, peakOf(1'b1));
                phase = 0;
            end else if (done) begin
                $display("done pulsed at %0t outside a finished run", $time);
                protErr++;
            end else if (busy && phase == 0) begin
                $display("busy is high at %0t although no run was started", $time);
                protErr++;
            end
        end
    end

endmodule

//--- tests/sifhTb.sv
module sifhTb;
    timeunit 1ns;
    timeprecision 100ps;
    import sifhPkg::*;

    localparam int drvDelay  = 5;      // ns after the rising edge
    localparam int busyLimit = 8;
    localparam int doneLimit = 2000;   // pass two peak search plus margin

    logic              clk;
    logic              res;
    logic              start;
    logic              eventValid;
    logic [stampW-1:0] stamp;
    logic              frameEnd;
    logic              busy;
    logic              done;
    peak_t             peak1;
    peak_t             peak2;
    window_t           window;

    peak_t   expPeak1;
    peak_t   expPeak2;
    window_t expWindow;
    int      valueErrors;
    int      modelErrors;
    int      protocolErrors;
    bit      aborted;
    int      runs;

    sifhTop dut0 (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .eventValid (eventValid),
        .stamp      (stamp),
        .frameEnd   (frameEnd),
        .busy       (busy),
        .done       (done),
        .peak1      (peak1),
        .peak2      (peak2),
        .window     (window)
    );

    sifhChecker check0 (
        .clk            (clk),
        .res            (res),
        .start          (start),
        .eventValid     (eventValid),
        .stamp          (stamp),
        .frameEnd       (frameEnd),
        .busy           (busy),
        .done           (done),
        .peak1          (peak1),
        .peak2          (peak2),
        .window         (window),
        .expPeak1       (expPeak1),
        .expPeak2       (expPeak2),
        .expWindow      (expWindow),
        .valueErrors    (valueErrors),
        .modelErrors    (modelErrors),
        .protocolErrors (protocolErrors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one clock cycle of stimulus with strobes that drop again on the next call
    task automatic driveCycle(input logic st, input logic ev,
                              input logic [stampW-1:0] sm, input logic fe);
        @(posedge clk);
        #drvDelay;
        start      = st;
        eventValid = ev;
        stamp      = sm;
        frameEnd   = fe;
    endtask

    task automatic waitFor(input bit forDone, input int limit, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < limit && !ok; n++) begin
            @(negedge clk);
            ok = forDone ? done : busy;
        end
    endtask

    initial begin
        int                fd;
        int                code;
        int                gap;
        int                b1;
        int                c1;
        int                lo;
        int                hi;
        int                b2;
        int                c2;
        logic [7:0]        kind;
        logic [stampW-1:0] st;
        logic [8*80-1:0]   line;
        bit                ok;
        start      = 1'b0;
        eventValid = 1'b0;
        stamp      = '0;
        frameEnd   = 1'b0;
        res        = 1'b0;
        expPeak1   = '0;
        expPeak2   = '0;
        expWindow  = '0;
        aborted    = 1'b0;
        runs       = 0;
        repeat (5) @(posedge clk);
        #drvDelay;
        res = 1'b1;
        fd = $fopen("tests/sifhTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tests/sifhTrace.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": code = $fgets(line, fd);
                "S": begin
                    driveCycle(1'b1, 1'b0, '0, 1'b0);
                    driveCycle(1'b0, 1'b0, '0, 1'b0);
                    waitFor(1'b0, busyLimit, ok);
                    if (!ok) begin
                        $display("busy did not rise within %0d cycles of start", busyLimit);
                        aborted = 1'b1;
                    end
                end
                "E": begin
                    code = $fscanf(fd, "%h %d", st, gap);
                    if (code != 2) begin
                        $display("an event line in the trace file is malformed");
                        aborted = 1'b1;
                    end else begin
                        repeat (gap - 1) driveCycle(1'b0, 1'b0, '0, 1'b0);
                        driveCycle(1'b0, 1'b1, st, 1'b0);
                    end
                end
                "F": driveCycle(1'b0, 1'b0, '0, 1'b1);
                "X": begin
                    code = $fscanf(fd, "%d %d %d %d %d %d", b1, c1, lo, hi, b2, c2);
                    if (code != 6) begin
                        $display("an expected-result line in the trace file is malformed");
                        aborted = 1'b1;
                    end else begin
                        expPeak1  = '{bin: binW'(b1), count: countW'(c1)};
                        expWindow = '{thLow: binW'(lo), thHigh: binW'(hi)};
                        expPeak2  = '{bin: binW'(b2), count: countW'(c2)};
                        driveCycle(1'b0, 1'b0, '0, 1'b0);
                        waitFor(1'b1, doneLimit, ok);
                        if (!ok) begin
                            $display("done did not arrive within %0d cycles", doneLimit);
                            aborted = 1'b1;
                        end
                        runs++;
                    end
                end
                default: begin
                    $display("unknown line type %c in the trace file", kind);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (4) driveCycle(1'b0, 1'b0, '0, 1'b0);
        $display("runs %0d, trace mismatches %0d, model mismatches %0d, protocol errors %0d",
                 runs, valueErrors, modelErrors, protocolErrors);
        if (!aborted && (valueErrors + modelErrors + protocolErrors) == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- tests/sifhTrace.txt
# S start | E stamp (hex) and cycles since the previous strobe | F frame end
# X peak1 bin, peak1 count, thLow, thHigh, peak2 bin, peak2 count
E 0C0 2
S
E 080 80
E 0BF 1
E 085 1
E 300 3
F
E 081 2
E 380 220
E 381 1
E 382 1
E 180 1
E 040 1
E 041 1
F
X 2 3 0 6 1 2
S
E F80 80
E FC0 1
E FC1 1
E F81 1
F
E E00 220
E E80 1
F
X 62 2 58 63 58 1
